/* common/ahb_pkg.sv */
package ahb_pkg;

  // **************************************************
  // Bus widths
  // **************************************************
  // Byte address across the whole slave
  localparam int ADDR_W = 8;
  // One bus word, four byte lanes
  localparam int DATA_W = 32;

  // Byte address as seen on HADDR
  typedef logic [ADDR_W-1:0] haddr_t;
  // Read or write data word
  typedef logic [DATA_W-1:0] hdata_t;

  // **************************************************
  // Transfer and size codes
  // **************************************************
  // HTRANS encoding
  typedef enum logic [1:0] {
    TRANS_IDLE = 2'd0,
    TRANS_BUSY = 2'd1,
    TRANS_NSEQ = 2'd2,
    TRANS_SEQ  = 2'd3
  } htrans_e;

  // Low two bits of HSIZE
  // Code 3 is not used by this slave
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } hsize_e;

  // **************************************************
  // Address map
  // **************************************************
  // Read window
  localparam haddr_t READ_MIN  = 8'd0;
  localparam haddr_t READ_MAX  = 8'd127;
  // Write window, overlaps the upper half of the read window
  localparam haddr_t WRITE_MIN = 8'd64;
  localparam haddr_t WRITE_MAX = 8'd255;

endpackage

/* common/slave_pkg.sv */
package slave_pkg;

  // **************************************************
  // Storage shape
  // **************************************************
  // One lane per byte of the bus word
  localparam int NUM_LANES  = 4;
  // Words of storage behind the 8-bit byte address
  localparam int MEM_WORDS  = 64;
  // Address bits that pick the lane inside a word
  localparam int LANE_SEL_W = $clog2(NUM_LANES);

  // Contents of a single lane entry
  typedef logic [7:0]                   lane_byte_t;
  // Index into the word array
  typedef logic [$clog2(MEM_WORDS)-1:0] word_addr_t;
  // One enable bit per lane
  typedef logic [NUM_LANES-1:0]         byte_en_t;

  // Everything the data phase needs from the address phase
  typedef struct packed {
    // Real NSEQ or SEQ transfer in flight
    logic       active;
    logic       write;
    // Address outside the window for this direction
    logic       err;
    word_addr_t word_addr;
    // Cleared on erroring transfers
    byte_en_t   byte_en;
  } dphase_t;

  // Response sequencing
  typedef enum logic [1:0] {
    RESP_OKAY = 2'd0,
    RESP_ERR1 = 2'd1,
    RESP_ERR2 = 2'd2
  } resp_state_e;

endpackage

/* verilog/ahb_addr_phase.sv */
module ahb_addr_phase (
  input  logic                tb_clk,
  input  logic                rst_i,
  input  logic                hsel_i,
  input  ahb_pkg::haddr_t     haddr_i,
  input  ahb_pkg::htrans_e    htrans_i,
  input  ahb_pkg::hsize_e     hsize_i,
  input  logic                hwrite_i,
  input  logic                hready_i,
  output slave_pkg::dphase_t  dphase_o
);

  import ahb_pkg::*;
  import slave_pkg::*;

  // Lane offset inside the addressed word
  logic [LANE_SEL_W-1:0] lane_ofs;
  // Transfer that wants service this cycle
  logic                  addr_valid;
  // Address falls in the window for its direction
  logic                  addr_legal;
  byte_en_t              size_mask;
  dphase_t               dphase_d;

  // Window test done as an offset compare
  // Below the low limit wraps to a large offset and fails
  function automatic logic in_window(haddr_t addr, haddr_t lo, haddr_t hi);
    haddr_t ofs;
    ofs = addr - lo;
    return ofs <= haddr_t'(hi - lo);
  endfunction

  // Lanes touched by a transfer of this size at this offset
  function automatic byte_en_t lane_mask(hsize_e size, logic [LANE_SEL_W-1:0] ofs);
    byte_en_t mask;
    case (size)
      SIZE_BYTE: mask = byte_en_t'(1) << ofs;
      // Halfword picks the low or high pair
      SIZE_HALF: mask = ofs[1] ? byte_en_t'(4'b1100) : byte_en_t'(4'b0011);
      default:   mask = '1;
    endcase
    return mask;
  endfunction

  // **************************************************
  // Address phase decode
  // **************************************************
  assign lane_ofs   = haddr_i[LANE_SEL_W-1:0];
  // IDLE and BUSY never reach the data phase
  assign addr_valid = hsel_i && ((htrans_i == TRANS_NSEQ) || (htrans_i == TRANS_SEQ));
  assign addr_legal = hwrite_i ? in_window(haddr_i, WRITE_MIN, WRITE_MAX)
                               : in_window(haddr_i, READ_MIN, READ_MAX);
  assign size_mask  = lane_mask(hsize_i, lane_ofs);

  always_comb begin
    dphase_d.active    = addr_valid;
    dphase_d.write     = addr_valid && hwrite_i;
    dphase_d.err       = addr_valid && !addr_legal;
    dphase_d.word_addr = haddr_i[ADDR_W-1:LANE_SEL_W];
    // No lane sees an enable for an illegal access
    dphase_d.byte_en   = (addr_valid && addr_legal) ? size_mask : '0;
  end

  // Hold the current data phase while the slave stalls
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      dphase_o <= '0;
    end else if (hready_i) begin
      dphase_o <= dphase_d;
    end
  end

  // Erroring write must leave every lane untouched
  a_err_write_no_en : assert property (
    @(posedge tb_clk) disable iff (rst_i)
    (dphase_o.active && dphase_o.err && dphase_o.write) |-> (dphase_o.byte_en == '0)
  ) else $error("erroring write carries byte enables %h", dphase_o.byte_en);

endmodule

/* verilog/mem_byte_lane.sv */
module mem_byte_lane (
  input  logic                  tb_clk,
  input  slave_pkg::dphase_t    dphase_i,
  input  slave_pkg::lane_byte_t wr_byte_i,
  input  logic                  lane_we_i,
  output slave_pkg::lane_byte_t rd_byte_o
);

  import slave_pkg::*;

  // **************************************************
  // Lane storage
  // **************************************************
  // One byte of every word, no reset on contents
  lane_byte_t mem [MEM_WORDS];

  // Store at the edge that closes the write data phase
  always_ff @(posedge tb_clk) begin
    if (lane_we_i) begin
      mem[dphase_i.word_addr] <= wr_byte_i;
    end
  end

  // Read path is combinational
  // A read right after a write sees the stored byte
  assign rd_byte_o = mem[dphase_i.word_addr];

endmodule

/* verilog/ahb_resp_ctrl.sv */
module ahb_resp_ctrl (
  input  logic                                             tb_clk,
  input  logic                                             rst_i,
  input  slave_pkg::dphase_t                               dphase_i,
  input  slave_pkg::lane_byte_t [slave_pkg::NUM_LANES-1:0] rd_bytes_i,
  output ahb_pkg::hdata_t                                  hrdata_o,
  output logic                                             hready_o,
  output logic                                             hresp_o
);

  import slave_pkg::*;

  // Response given in the previous cycle
  resp_state_e state_q;
  // Response for the current cycle
  resp_state_e resp_state;
  // Data phase of a legal read
  logic        rd_legal;

  // **************************************************
  // Response FSM
  // **************************************************
  // First error cycle comes straight from the data phase
  // Second error cycle always follows the first
  always_comb begin
    if (state_q == RESP_ERR1) begin
      resp_state = RESP_ERR2;
    end else if (dphase_i.active && dphase_i.err) begin
      resp_state = RESP_ERR1;
    end else begin
      resp_state = RESP_OKAY;
    end
  end

  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      state_q <= RESP_OKAY;
    end else begin
      state_q <= resp_state;
    end
  end

  // Wait state only in the first error cycle
  assign hready_o = (resp_state != RESP_ERR1);
  // ERROR held across both error cycles
  assign hresp_o  = (resp_state != RESP_OKAY);

  // **************************************************
  // Read data
  // **************************************************
  assign rd_legal = dphase_i.active && !dphase_i.write && !dphase_i.err;

  // Lane 0 lands in the low byte
  always_comb begin
    hrdata_o = '0;
    if (rd_legal) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        hrdata_o[i*$bits(lane_byte_t) +: $bits(lane_byte_t)] = rd_bytes_i[i];
      end
    end
  end

  // Wait state only ever comes with ERROR
  a_wait_is_err : assert property (
    @(posedge tb_clk) disable iff (rst_i)
    !hready_o |-> hresp_o
  ) else $error("hready low without hresp");

  // Two-cycle error never cut short
  a_err1_then_err2 : assert property (
    @(posedge tb_clk) disable iff (rst_i)
    (resp_state == RESP_ERR1) |=> (resp_state == RESP_ERR2)
  ) else $error("error response not followed by second cycle");

endmodule

/* verilog/ahb_mem_slave.sv */
module ahb_mem_slave (
  input  logic             tb_clk,
  input  logic             rst_i,
  input  logic             hsel_i,
  input  ahb_pkg::haddr_t  haddr_i,
  input  ahb_pkg::htrans_e htrans_i,
  input  ahb_pkg::hsize_e  hsize_i,
  input  logic             hwrite_i,
  input  ahb_pkg::hdata_t  hwdata_i,
  output ahb_pkg::hdata_t  hrdata_o,
  output logic             hresp_o,
  output logic             hready_o
);

  import slave_pkg::*;

  // Registered data phase shared by lanes and response
  dphase_t                     dphase;
  // One read byte per lane
  lane_byte_t [NUM_LANES-1:0]  rd_bytes;

  // **************************************************
  // Address phase
  // **************************************************
  ahb_addr_phase u_addr_phase (
    .tb_clk   (tb_clk),
    .rst_i    (rst_i),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hwrite_i (hwrite_i),
    // Stalls capture during the first error cycle
    .hready_i (hready_o),
    .dphase_o (dphase)
  );

  // **************************************************
  // Byte lanes
  // **************************************************
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    // Each lane takes its own byte of the write data
    mem_byte_lane u_lane (
      .tb_clk    (tb_clk),
      .dphase_i  (dphase),
      .wr_byte_i (hwdata_i[i*$bits(lane_byte_t) +: $bits(lane_byte_t)]),
      .lane_we_i (dphase.write && dphase.byte_en[i]),
      .rd_byte_o (rd_bytes[i])
    );
  end

  // Response and read data
  ahb_resp_ctrl u_resp_ctrl (
    .tb_clk     (tb_clk),
    .rst_i      (rst_i),
    .dphase_i   (dphase),
    .rd_bytes_i (rd_bytes),
    .hrdata_o   (hrdata_o),
    .hready_o   (hready_o),
    .hresp_o    (hresp_o)
  );

endmodule

/* verif/ahb_slave_checker.sv */
module ahb_slave_checker (
  input  logic             tb_clk,
  input  logic             rst_i,
  input  logic             hsel_i,
  input  ahb_pkg::haddr_t  haddr_i,
  input  ahb_pkg::htrans_e htrans_i,
  input  ahb_pkg::hdata_t  hrdata_i,
  input  logic             hresp_i,
  input  logic             hready_i,
  output logic             done_o,
  output int               value_errs_o,
  output int               other_errs_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import ahb_pkg::*;

  // One transfer as listed in the stim file
  typedef struct packed {
    logic [1:0] htrans;
    logic       write;
    haddr_t     addr;
    logic [1:0] size;
    hdata_t     wdata;
    logic       exp_err;
    hdata_t     exp_rdata;
  } stim_line_t;

  stim_line_t lines [$];
  int         value_errs    = 0;
  int         other_errs    = 0;
  int         load_errs     = 0;
  // Next stim line to pair with an address phase
  int         accept_idx    = 0;
  // Line whose data phase is on the bus
  int         pend_idx      = 0;
  int         done_cnt      = 0;
  logic       pend_valid    = 1'b0;
  // First error cycle already seen for this line
  logic       wait_seen     = 1'b0;
  logic       reset_checked = 1'b0;
  logic       done_q        = 1'b0;

  assign done_o       = done_q;
  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs + load_errs;

  // **************************************************
  // Expected values
  // **************************************************
  initial begin
    int          fd;
    int          nf;
    string       text;
    logic [31:0] fld [7];
    stim_line_t  rec;
    fd = $fopen("verif/ahb_slave_stim.txt", "r");
    if (fd == 0) begin
      $display("checker cannot open the stimulus file");
      load_errs = 1;
    end else begin
      while ($fgets(text, fd) != 0) begin
        nf = $sscanf(text, "%h %h %h %h %h %h %h",
                     fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
        // Comment lines match no field
        if (nf == 7) begin
          rec.htrans    = fld[0][1:0];
          rec.write     = fld[1][0];
          rec.addr      = fld[2][7:0];
          rec.size      = fld[3][1:0];
          rec.wdata     = fld[4];
          rec.exp_err   = fld[5][0];
          rec.exp_rdata = fld[6];
          lines.push_back(rec);
        end
      end
      $fclose(fd);
    end
  end

  task automatic check_value(string sig, string ctx, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s %s: got %0h expected %0h", sig, ctx, got, exp);
      value_errs++;
    end
  endtask

  // One data-phase cycle of the pending line just ended
  task automatic close_cycle();
    stim_line_t ln;
    string      ctx;
    ln  = lines[pend_idx];
    ctx = $sformatf("on stim line %0d", pend_idx);
    if (!hready_i) begin
      // Wait state, only the first error cycle may stall
      if (!ln.exp_err || wait_seen) begin
        $display("unexpected wait state in the data phase of stim line %0d", pend_idx);
        other_errs++;
      end
      check_value("hresp_o", ctx, 32'(hresp_i), 32'h1);
      wait_seen = 1'b1;
    end else begin
      if (ln.exp_err && !wait_seen) begin
        $display("error response of stim line %0d came without its wait cycle", pend_idx);
        other_errs++;
      end
      check_value("hresp_o", ctx, 32'(hresp_i), 32'(ln.exp_err));
      // Zero outside legal reads
      check_value("hrdata_o", ctx, hrdata_i, ln.exp_rdata);
      pend_valid = 1'b0;
      done_cnt++;
    end
  endtask

  // **************************************************
  // Bus monitor
  // **************************************************
  always @(posedge tb_clk) begin
    if (!rst_i) begin
      // Idle response on the first cycle out of reset
      if (!reset_checked) begin
        check_value("hready_o", "after reset", 32'(hready_i), 32'h1);
        check_value("hresp_o", "after reset", 32'(hresp_i), 32'h0);
        reset_checked = 1'b1;
      end
      if (pend_valid) begin
        close_cycle();
      end
      // Address phase taken by the slave at this edge
      if (hready_i && hsel_i && (accept_idx < lines.size())) begin
        if ((haddr_i !== lines[accept_idx].addr) ||
            (htrans_i !== htrans_e'(lines[accept_idx].htrans))) begin
          $display("bus address phase does not match stim line %0d", accept_idx);
          other_errs++;
        end
        pend_idx   = accept_idx;
        pend_valid = 1'b1;
        wait_seen  = 1'b0;
        accept_idx++;
      end
      done_q <= (done_cnt == lines.size());
    end
  end

endmodule

/* verif/tb_ahb_mem_slave.sv */
module tb_ahb_mem_slave;

  timeunit 1ns;
  timeprecision 100ps;

  import ahb_pkg::*;

  localparam int RESET_CYCLES = 10;

  // Same record layout as the checker reads
  typedef struct packed {
    logic [1:0] htrans;
    logic       write;
    haddr_t     addr;
    logic [1:0] size;
    hdata_t     wdata;
    logic       exp_err;
    hdata_t     exp_rdata;
  } stim_line_t;

  logic       tb_clk;
  logic       rst_i;
  logic       hsel_i;
  haddr_t     haddr_i;
  htrans_e    htrans_i;
  hsize_e     hsize_i;
  logic       hwrite_i;
  hdata_t     hwdata_i;
  hdata_t     hrdata_o;
  logic       hresp_o;
  logic       hready_o;
  logic       chk_done;
  int         chk_value_errs;
  int         chk_other_errs;
  stim_line_t lines [$];
  int         setup_errs  = 0;
  logic       stim_loaded = 1'b0;

  ahb_mem_slave dut0 (
    .tb_clk   (tb_clk),
    .rst_i    (rst_i),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hresp_o  (hresp_o),
    .hready_o (hready_o)
  );

  ahb_slave_checker u_checker (
    .tb_clk       (tb_clk),
    .rst_i        (rst_i),
    .hsel_i       (hsel_i),
    .haddr_i      (haddr_i),
    .htrans_i     (htrans_i),
    .hrdata_i     (hrdata_o),
    .hresp_i      (hresp_o),
    .hready_i     (hready_o),
    .done_o       (chk_done),
    .value_errs_o (chk_value_errs),
    .other_errs_o (chk_other_errs)
  );

  initial begin
    tb_clk = 1'b0;
    forever #5 tb_clk = ~tb_clk;
  end

  task automatic read_stim_file();
    int          fd;
    int          nf;
    string       text;
    logic [31:0] fld [7];
    stim_line_t  rec;
    fd = $fopen("verif/ahb_slave_stim.txt", "r");
    if (fd == 0) begin
      $display("driver cannot open the stimulus file");
      setup_errs++;
      return;
    end
    while ($fgets(text, fd) != 0) begin
      nf = $sscanf(text, "%h %h %h %h %h %h %h",
                   fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
      if (nf == 7) begin
        rec.htrans    = fld[0][1:0];
        rec.write     = fld[1][0];
        rec.addr      = fld[2][7:0];
        rec.size      = fld[3][1:0];
        rec.wdata     = fld[4];
        rec.exp_err   = fld[5][0];
        rec.exp_rdata = fld[6];
        lines.push_back(rec);
      end
    end
    $fclose(fd);
    if (lines.size() == 0) begin
      $display("stimulus file holds no transfers");
      setup_errs++;
    end
  endtask

  // Address phase of one stim line
  task automatic drive_addr(stim_line_t ln);
    hsel_i   <= 1'b1;
    htrans_i <= htrans_e'(ln.htrans);
    hwrite_i <= ln.write;
    haddr_i  <= ln.addr;
    hsize_i  <= hsize_e'(ln.size);
  endtask

  task automatic drive_idle();
    hsel_i   <= 1'b0;
    htrans_i <= TRANS_IDLE;
    hwrite_i <= 1'b0;
  endtask

  // **************************************************
  // Pipelined bus driver
  // **************************************************
  initial begin
    int idx;
    rst_i    = 1'b1;
    hsel_i   = 1'b0;
    haddr_i  = '0;
    htrans_i = TRANS_IDLE;
    hsize_i  = SIZE_WORD;
    hwrite_i = 1'b0;
    hwdata_i = '0;
    read_stim_file();
    stim_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge tb_clk);
    rst_i <= 1'b0;
    @(posedge tb_clk);
    if (lines.size() > 0) begin
      drive_addr(lines[0]);
    end
    idx = 0;
    while (idx < lines.size()) begin
      @(posedge tb_clk);
      // Held while the slave inserts a wait state
      if (hready_o) begin
        hwdata_i <= lines[idx].wdata;
        idx++;
        if (idx < lines.size()) begin
          drive_addr(lines[idx]);
        end else begin
          drive_idle();
        end
      end
    end
    while (!chk_done) @(posedge tb_clk);
    $display("value errors %0d, other errors %0d", chk_value_errs, chk_other_errs + setup_errs);
    if ((chk_value_errs == 0) && (chk_other_errs == 0) && (setup_errs == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of four cycles per transfer, offset off the clock edge
  initial begin
    wait (stim_loaded);
    repeat (lines.size() * 4 + RESET_CYCLES) @(posedge tb_clk);
    #1;
    $display("watchdog expired before all transfers completed");
    $display("Test failures found");
    $finish;
  end

endmodule

/* verif/ahb_slave_stim.txt */
# htrans(0 idle 1 busy 2 nseq 3 seq) write addr size(0 byte 1 half 2 word) wdata resp rdata
# all hex, resp 0 okay 1 error, rdata expected in the data phase
# idle and busy out of reset
0 0 00 2 00000000 0 00000000
1 0 00 2 00000000 0 00000000
# word write and immediate read back
2 1 40 2 deadbeef 0 00000000
2 0 40 2 00000000 0 deadbeef
# narrow writes merged into one word
2 1 44 2 11223344 0 00000000
2 1 45 0 0000aa00 0 00000000
2 0 44 2 00000000 0 1122aa44
2 1 46 1 bbcc0000 0 00000000
2 0 44 2 00000000 0 bbccaa44
2 1 47 0 ee000000 0 00000000
2 1 44 1 00005566 0 00000000
2 0 44 2 00000000 0 eecc5566
# incrementing burst with a busy beat
2 1 50 2 a0000001 0 00000000
3 1 54 2 a0000002 0 00000000
1 1 58 2 00000000 0 00000000
3 1 58 2 a0000003 0 00000000
3 1 5c 2 a0000004 0 00000000
2 0 50 2 00000000 0 a0000001
3 0 54 2 00000000 0 a0000002
1 0 58 2 00000000 0 00000000
3 0 58 2 00000000 0 a0000003
3 0 5c 2 00000000 0 a0000004
# wrapping burst 68 72 76 64
2 1 44 2 c0000044 0 00000000
3 1 48 2 c0000048 0 00000000
1 1 4c 2 00000000 0 00000000
3 1 4c 2 c000004c 0 00000000
3 1 40 2 c0000040 0 00000000
2 0 44 2 00000000 0 c0000044
3 0 48 2 00000000 0 c0000048
3 0 4c 2 00000000 0 c000004c
3 0 40 2 00000000 0 c0000040
# illegal writes low and reads high
2 1 10 2 55555555 1 00000000
2 1 3f 0 ff000000 1 00000000
2 0 80 2 00000000 1 00000000
2 0 fc 2 00000000 1 00000000
2 0 50 2 00000000 0 a0000001
# overlap word and write-only region
2 1 7c 2 12345678 0 00000000
2 0 7c 2 00000000 0 12345678
2 1 c8 2 cafef00d 0 00000000
2 0 c8 2 00000000 1 00000000
0 0 00 2 00000000 0 00000000

/* ahb_mem_slave.f */
common/ahb_pkg.sv
common/slave_pkg.sv
verilog/ahb_addr_phase.sv
verilog/mem_byte_lane.sv
verilog/ahb_resp_ctrl.sv
verilog/ahb_mem_slave.sv
verif/ahb_slave_checker.sv
verif/tb_ahb_mem_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AHB memory slave testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f ahb_mem_slave.f \
  --top-module tb_ahb_mem_slave --Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# The log decides the verdict
if grep -q "Test failures found" "$log_file"; then
  exit 1
fi
exit 0
